// File: design/uart_pkg.sv
// 8N1 framing with optional parity; clk_divider is integer cycles per bit and must be 4 or more.
package uart_pkg;

    localparam int DATA_WIDTH    = 8;
    localparam int DIVIDER_WIDTH = 16;
    localparam int BIT_CNT_WIDTH = $clog2(DATA_WIDTH);

    typedef logic [DATA_WIDTH-1:0]    uart_data_t;
    typedef logic [DIVIDER_WIDTH-1:0] uart_div_t;
    typedef logic [BIT_CNT_WIDTH-1:0] uart_bit_cnt_t;

    localparam uart_div_t     DIV_MIN  = uart_div_t'(4);          // Smallest usable divider.
    localparam uart_bit_cnt_t BIT_LAST = BIT_CNT_WIDTH'(DATA_WIDTH - 1);

    // Odd parity takes priority when both flags are set.
    typedef struct packed {
        uart_div_t clk_divider;
        logic      parity_odd;
        logic      parity_even;
    } uart_cfg_t;

    typedef struct packed {
        logic parity_err;
        logic frame_err;   // Stop bit sampled low.
        logic overrun;     // Frame finished while a byte was still unread.
    } uart_status_t;

    // Parity bit that goes on the line for this byte.
    function automatic logic uart_parity(
        input uart_data_t data,
        input logic       odd,
        input logic       even
    );
        logic bit_val;
        bit_val = 1'b0;
        if (odd) begin
            bit_val = ~^data;
        end else if (even) begin
            bit_val = ^data;
        end
        return bit_val;
    endfunction

endpackage

// File: design/uart_rx.sv
// Mid-bit sampling with a one-byte hold register; frames that finish while it is full are lost.
`timescale 1ns/100ps

module uart_rx
    import uart_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  uart_cfg_t    cfg_i,
    input  logic         rx_i,
    output uart_data_t   m_tdata_o,
    output uart_status_t m_status_o,
    output logic         m_tvalid_o,
    input  logic         m_tready_i
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    rx_state_e     state_q;
    logic          rx_meta_q;
    logic          rx_sync_q;
    logic          rx_prev_q;
    uart_div_t     sample_cnt_q;
    uart_bit_cnt_t bit_cnt_q;
    uart_data_t    shift_q;
    logic          parity_err_q;
    uart_data_t    m_tdata_q;
    uart_status_t  m_status_q;
    logic          m_tvalid_q;
    logic          start_edge;
    logic          sample_tick;
    logic          frame_done;
    logic          out_free;
    logic          parity_en;

    assign parity_en   = cfg_i.parity_odd || cfg_i.parity_even;
    assign start_edge  = (state_q == RX_IDLE) && rx_prev_q && !rx_sync_q;
    assign sample_tick = (state_q != RX_IDLE) && (sample_cnt_q == '0);
    assign frame_done  = (state_q == RX_STOP) && sample_tick;
    assign out_free    = !m_tvalid_q || m_tready_i;   // Held byte is gone after this edge.

    assign m_tdata_o  = m_tdata_q;
    assign m_status_o = m_status_q;
    assign m_tvalid_o = m_tvalid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= RX_IDLE;
            sample_cnt_q <= '0;
            bit_cnt_q    <= '0;
        end else begin
            if (state_q != RX_IDLE) begin
                sample_cnt_q <= sample_tick ? cfg_i.clk_divider - 1'b1
                                            : sample_cnt_q - 1'b1;
            end
            case (state_q)
                RX_IDLE: begin
                    if (start_edge) begin
                        state_q      <= RX_START;
                        sample_cnt_q <= (cfg_i.clk_divider >> 1) - 1'b1;   // Half a bit.
                    end
                end
                RX_START: begin
                    if (sample_tick) begin
                        if (rx_sync_q) begin
                            state_q <= RX_IDLE;   // Glitch, not a start bit.
                        end else begin
                            state_q   <= RX_DATA;
                            bit_cnt_q <= '0;
                        end
                    end
                end
                RX_DATA: begin
                    if (sample_tick) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BIT_LAST) begin
                            state_q <= parity_en ? RX_PARITY : RX_STOP;
                        end
                    end
                end
                RX_PARITY: begin
                    if (sample_tick) begin
                        state_q <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (sample_tick) begin
                        state_q <= RX_IDLE;
                    end
                end
                default: begin
                    state_q <= RX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && sample_tick) begin
            shift_q <= {rx_sync_q, shift_q[DATA_WIDTH-1:1]};   // LSB first.
        end
        if (start_edge) begin
            parity_err_q <= 1'b0;
        end else if (state_q == RX_PARITY && sample_tick) begin
            parity_err_q <= rx_sync_q != uart_parity(shift_q, cfg_i.parity_odd,
                                                     cfg_i.parity_even);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            m_tvalid_q <= 1'b0;
        end else if (frame_done && out_free) begin
            m_tvalid_q <= 1'b1;
        end else if (m_tready_i) begin
            m_tvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (frame_done) begin
            if (out_free) begin
                m_tdata_q             <= shift_q;
                m_status_q.parity_err <= parity_err_q;
                m_status_q.frame_err  <= !rx_sync_q;
                m_status_q.overrun    <= 1'b0;
            end else begin
                m_status_q.overrun <= 1'b1;   // New frame dropped.
            end
        end
    end

    a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o))
        else $error("rx output changed while stalled");

    a_div_min: assert property (@(posedge clk_i) disable iff (rst_i)
        start_edge |-> cfg_i.clk_divider >= DIV_MIN)
        else $error("rx frame started with divider below minimum");

endmodule

// File: design/uart_top.sv
// TX and RX are independent; both read cfg_i, which should only change while both are idle.
`timescale 1ns/100ps

module uart_top
    import uart_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  uart_cfg_t    cfg_i,

    // Transmit stream.
    input  uart_data_t   tx_tdata_i,
    input  logic         tx_tvalid_i,
    output logic         tx_tready_o,

    // Serial lines.
    output logic         tx_o,
    input  logic         rx_i,

    // Receive stream.
    output uart_data_t   rx_tdata_o,
    output uart_status_t rx_status_o,
    output logic         rx_tvalid_o,
    input  logic         rx_tready_i
);

    uart_tx u_tx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cfg_i      (cfg_i),
        .s_tdata_i  (tx_tdata_i),
        .s_tvalid_i (tx_tvalid_i),
        .s_tready_o (tx_tready_o),
        .tx_o       (tx_o)
    );

    uart_rx u_rx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cfg_i      (cfg_i),
        .rx_i       (rx_i),
        .m_tdata_o  (rx_tdata_o),
        .m_status_o (rx_status_o),
        .m_tvalid_o (rx_tvalid_o),
        .m_tready_i (rx_tready_i)
    );

endmodule

// File: design/uart_tx.sv
// Sends one byte per tvalid/tready transfer; cfg_i must not change while a frame is on the line.
`timescale 1ns/100ps

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  uart_cfg_t  cfg_i,
    input  uart_data_t s_tdata_i,
    input  logic       s_tvalid_i,
    output logic       s_tready_o,
    output logic       tx_o
);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP,
        TX_WAIT
    } tx_state_e;

    tx_state_e     state_q;
    tx_state_e     state_d;
    uart_bit_cnt_t bit_cnt_q;
    uart_bit_cnt_t bit_cnt_d;
    uart_div_t     baud_cnt_q;
    uart_data_t    tx_data_q;
    logic          tx_q;
    logic          tx_d;
    logic          frame_active;
    logic          baud_done;
    logic          bit_done;
    logic          parity_en;
    logic          parity_bit;
    logic          handshake;

    assign s_tready_o   = (state_q == TX_IDLE) && !rst_i;
    assign handshake    = s_tvalid_i && s_tready_o;
    assign parity_en    = cfg_i.parity_odd || cfg_i.parity_even;
    assign parity_bit   = uart_parity(tx_data_q, cfg_i.parity_odd, cfg_i.parity_even);
    assign frame_active = (state_q inside {TX_START, TX_DATA, TX_PARITY, TX_STOP});
    assign baud_done    = frame_active && (baud_cnt_q == cfg_i.clk_divider - 1'b1);
    assign bit_done     = (bit_cnt_q == BIT_LAST);
    assign tx_o         = tx_q;

    always_comb begin
        state_d   = state_q;
        bit_cnt_d = bit_cnt_q;
        case (state_q)
            TX_IDLE: begin
                if (handshake) begin
                    state_d = TX_START;
                end
            end
            TX_START: begin
                if (baud_done) begin
                    state_d   = TX_DATA;
                    bit_cnt_d = '0;
                end
            end
            TX_DATA: begin
                if (baud_done) begin
                    if (bit_done) begin
                        bit_cnt_d = '0;
                        state_d   = parity_en ? TX_PARITY : TX_STOP;
                    end else begin
                        bit_cnt_d = bit_cnt_q + 1'b1;
                    end
                end
            end
            TX_PARITY: begin
                if (baud_done) begin
                    state_d = TX_STOP;
                end
            end
            TX_STOP: begin
                if (baud_done) begin
                    state_d = TX_WAIT;
                end
            end
            TX_WAIT: begin
                state_d = TX_IDLE;   // One idle cycle between frames.
            end
            default: begin
                state_d = TX_IDLE;
            end
        endcase
    end

    // Line level for the state being entered, so tx_o changes on the bit boundary.
    always_comb begin
        case (state_d)
            TX_START:  tx_d = 1'b0;
            TX_DATA:   tx_d = tx_data_q[bit_cnt_d];
            TX_PARITY: tx_d = parity_bit;
            default:   tx_d = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= TX_IDLE;
            bit_cnt_q <= '0;
            tx_q      <= 1'b1;
        end else begin
            state_q   <= state_d;
            bit_cnt_q <= bit_cnt_d;
            tx_q      <= tx_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            baud_cnt_q <= '0;
        end else if (!frame_active || baud_done) begin
            baud_cnt_q <= '0;
        end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (handshake) begin
            tx_data_q <= s_tdata_i;
        end
    end

    a_start_after_transfer: assert property (@(posedge clk_i) disable iff (rst_i)
        handshake |=> state_q == TX_START && !tx_o)
        else $error("tx start bit missing after transfer");

    a_idle_line_high: assert property (@(posedge clk_i) disable iff (rst_i)
        state_q == TX_IDLE |-> tx_o)
        else $error("tx line low while idle");

endmodule

// File: project.f
design/uart_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
sim/tb_uart.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_uart

verilator --binary --timing --assert --top-module tb_uart -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

"./$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/tb_uart.sv
// Runs with clk_divider fixed at 8 and seed 61; rx_i is tx_o in loopback, else the frame driver.
`timescale 1ns/100ps

module tb_uart
    import uart_pkg::*;
();

    localparam int DIV        = 8;
    localparam int N_PLAIN    = 16;
    localparam int N_PARITY   = 8;
    localparam int FRAME_MAX  = 12 * DIV;                 // Parity frame plus idle gap.
    localparam int N_FRAMES   = N_PLAIN + 2 * N_PARITY + 4;
    localparam int TIMEOUT    = N_FRAMES * FRAME_MAX * 3 / 2;
    localparam int PAR_SAMPLE = 9 * DIV + DIV / 2;        // Middle of the tenth bit.

    logic         clk;
    logic         rst;
    uart_cfg_t    cfg;
    uart_data_t   tx_tdata;
    logic         tx_tvalid;
    logic         tx_tready;
    logic         tx_line;
    logic         rx_line;
    logic         drv_line;
    logic         loopback;
    uart_data_t   rx_tdata;
    uart_status_t rx_status;
    logic         rx_tvalid;
    logic         rx_tready;

    uart_data_t   exp_data[$];
    uart_status_t exp_status[$];
    uart_data_t   head_data;
    uart_status_t head_status;
    logic         head_valid;
    logic         tx_par_exp;
    logic         par_en;
    int           frame_cycles;
    int           tx_cyc;                                 // Cycles since the last TX transfer.
    int           rx_got;
    int           errors;
    int           err_mark;
    int           pass_cnt;
    int           fail_cnt;
    int           cycles;
    integer       seed;

    assign rx_line      = loopback ? tx_line : drv_line;
    assign par_en       = cfg.parity_odd || cfg.parity_even;
    assign frame_cycles = (par_en ? 11 : 10) * DIV;

    uart_top DUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .cfg_i       (cfg),
        .tx_tdata_i  (tx_tdata),
        .tx_tvalid_i (tx_tvalid),
        .tx_tready_o (tx_tready),
        .tx_o        (tx_line),
        .rx_i        (rx_line),
        .rx_tdata_o  (rx_tdata),
        .rx_status_o (rx_status),
        .rx_tvalid_o (rx_tvalid),
        .rx_tready_i (rx_tready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Parity from the count of ones; odd parity makes the total count odd.
    function automatic logic expected_parity(input uart_data_t b, input logic odd, input logic even);
        int   ones;
        int   i;
        logic result;
        ones   = 0;
        result = 1'b0;
        for (i = 0; i < DATA_WIDTH; i++) begin
            if (b[i]) begin
                ones++;
            end
        end
        if (odd) begin
            result = (ones % 2) == 0;
        end else if (even) begin
            result = (ones % 2) == 1;
        end
        return result;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            tx_cyc <= 0;
        end else if (tx_tvalid && tx_tready) begin
            tx_cyc     <= 1;
            tx_par_exp <= expected_parity(tx_tdata, cfg.parity_odd, cfg.parity_even);
        end else if (tx_cyc > frame_cycles + 1) begin
            tx_cyc <= 0;
        end else if (tx_cyc != 0) begin
            tx_cyc <= tx_cyc + 1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            rx_got <= 0;
        end else if (rx_tvalid && rx_tready) begin
            rx_got <= rx_got + 1;
            if (exp_data.size() != 0) begin
                void'(exp_data.pop_front());
                void'(exp_status.pop_front());
            end
        end
        head_valid  <= exp_data.size() != 0;
        head_data   <= (exp_data.size() != 0) ? exp_data[0] : '0;
        head_status <= (exp_status.size() != 0) ? exp_status[0] : '0;
    end

    a_rx_expected: assert property (@(posedge clk) disable iff (rst)
        rx_tvalid && rx_tready |-> head_valid)
        else begin
            $display("Error at %0t: rx stream delivered a byte that was never sent", $time);
            errors++;
        end

    a_rx_data: assert property (@(posedge clk) disable iff (rst)
        rx_tvalid && rx_tready && head_valid |-> rx_tdata == head_data)
        else begin
            $display("Error at %0t: rx_tdata_o = %h, expected %h",
                     $time, $sampled(rx_tdata), $sampled(head_data));
            errors++;
        end

    a_rx_status: assert property (@(posedge clk) disable iff (rst)
        rx_tvalid && rx_tready && head_valid |-> rx_status == head_status)
        else begin
            $display("Error at %0t: rx_status_o = %b, expected %b",
                     $time, $sampled(rx_status), $sampled(head_status));
            errors++;
        end

    a_rx_hold: assert property (@(posedge clk) disable iff (rst)
        rx_tvalid && !rx_tready |=> rx_tvalid && $stable(rx_tdata))
        else begin
            $display("Error at %0t: rx output dropped or changed while rx_tready_i was low", $time);
            errors++;
        end

    a_tx_busy: assert property (@(posedge clk) disable iff (rst)
        tx_cyc >= 1 && tx_cyc <= frame_cycles + 1 |-> !tx_tready)
        else begin
            $display("Error at %0t: tx_tready_o = 1, expected 0", $time);
            errors++;
        end

    a_tx_free: assert property (@(posedge clk) disable iff (rst)
        tx_cyc == frame_cycles + 2 |-> tx_tready)
        else begin
            $display("Error at %0t: tx_tready_o = 0, expected 1", $time);
            errors++;
        end

    a_tx_parity: assert property (@(posedge clk) disable iff (rst)
        par_en && tx_cyc == PAR_SAMPLE |-> tx_line == tx_par_exp)
        else begin
            $display("Error at %0t: tx_o = %b, expected %b",
                     $time, $sampled(tx_line), $sampled(tx_par_exp));
            errors++;
        end

    task automatic expect_rx(input uart_data_t b, input uart_status_t st);
        exp_data.push_back(b);
        exp_status.push_back(st);
    endtask

    task automatic send_byte(input uart_data_t b);
        expect_rx(b, '0);
        tx_tdata  = b;
        tx_tvalid = 1'b1;
        while (!tx_tready) @(negedge clk);
        @(negedge clk);
        tx_tvalid = 1'b0;
    endtask

    task automatic drive_frame(input uart_data_t b, input logic bad_parity, input logic low_stop);
        int i;
        drv_line = 1'b0;
        repeat (DIV) @(negedge clk);
        for (i = 0; i < DATA_WIDTH; i++) begin
            drv_line = b[i];
            repeat (DIV) @(negedge clk);
        end
        if (par_en) begin
            drv_line = expected_parity(b, cfg.parity_odd, cfg.parity_even) ^ bad_parity;
            repeat (DIV) @(negedge clk);
        end
        drv_line = !low_stop;
        repeat (DIV) @(negedge clk);
        drv_line = 1'b1;
        repeat (DIV) @(negedge clk);                     // Idle gap before the next start bit.
    endtask

    task automatic drain_rx();
        while (exp_data.size() != 0) @(negedge clk);
        repeat (2 * DIV) @(negedge clk);
    endtask

    task automatic run_loopback(input logic odd, input logic even, input int count);
        int n;
        cfg.parity_odd  = odd;
        cfg.parity_even = even;
        loopback        = 1'b1;
        for (n = 0; n < count; n++) begin
            send_byte(uart_data_t'($random(seed)));
        end
        drain_rx();
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d error(s)", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("sim failed");
        $finish;
    end

    initial begin
        uart_data_t   b;
        uart_status_t st;
        int           got_mark;
        seed            = 61;
        errors          = 0;
        err_mark        = 0;
        pass_cnt        = 0;
        fail_cnt        = 0;
        rst             = 1'b1;
        cfg             = '0;
        cfg.clk_divider = uart_div_t'(DIV);
        tx_tdata        = '0;
        tx_tvalid       = 1'b0;
        drv_line        = 1'b1;
        loopback        = 1'b1;
        rx_tready       = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (tx_line == 1'b1) else begin
            $display("Error at %0t: tx_o = %b, expected 1", $time, tx_line);
            errors++;
        end
        assert (tx_tready == 1'b1) else begin
            $display("Error at %0t: tx_tready_o = %b, expected 1", $time, tx_tready);
            errors++;
        end
        assert (rx_tvalid == 1'b0) else begin
            $display("Error at %0t: rx_tvalid_o = %b, expected 0", $time, rx_tvalid);
            errors++;
        end
        end_test("reset_state");

        run_loopback(1'b0, 1'b0, N_PLAIN);
        end_test("loopback_no_parity");
        run_loopback(1'b0, 1'b1, N_PARITY);
        end_test("loopback_even_parity");
        run_loopback(1'b1, 1'b0, N_PARITY);
        end_test("loopback_odd_parity");

        loopback        = 1'b0;
        cfg.parity_odd  = 1'b0;
        cfg.parity_even = 1'b1;
        b               = uart_data_t'($random(seed));
        st              = '0;
        st.parity_err   = 1'b1;
        expect_rx(b, st);
        drive_frame(b, 1'b1, 1'b0);
        drain_rx();
        end_test("parity_error");

        cfg.parity_even = 1'b0;
        b               = uart_data_t'($random(seed));
        st              = '0;
        st.frame_err    = 1'b1;
        expect_rx(b, st);
        drive_frame(b, 1'b0, 1'b1);
        drain_rx();
        end_test("stop_bit_low");

        rx_tready  = 1'b0;
        got_mark   = rx_got;
        b          = uart_data_t'($random(seed));
        st         = '0;
        st.overrun = 1'b1;                               // Second frame is dropped.
        expect_rx(b, st);
        drive_frame(b, 1'b0, 1'b0);
        drive_frame(uart_data_t'($random(seed)), 1'b0, 1'b0);
        assert (rx_tvalid && rx_status.overrun) else begin
            $display("Error at %0t: held byte is missing or its overrun bit is clear", $time);
            errors++;
        end
        rx_tready = 1'b1;
        drain_rx();
        assert (rx_got == got_mark + 1) else begin
            $display("Error at %0t: rx transfers = %0d, expected %0d",
                     $time, rx_got - got_mark, 1);
            errors++;
        end
        end_test("back_pressure");

        $display("results: %0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
